// File: Bender.yml
package:
  name: csr_unit

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_decode.sv
  - rtl/csr_file.sv
  - rtl/trap_redirect.sv
  - rtl/csr_unit_top.sv
  - target: test
    files:
      - testbench/csr_unit_checker.sv
      - testbench/tb_csr_unit.sv

// File: rtl/csr_decode.sv
`timescale 1ns/1ns
module csr_decode (
    input  logic [31:0]        instr_i,
    output csr_pkg::csr_req_t  csr_req_o,
    output csr_pkg::trap_evt_t trap_evt_o
);
    import csr_pkg::*;

    logic        is_system;
    logic [2:0]  funct3;
    logic [11:0] imm;

    // full 32-bit encoding only
    assign is_system = (instr_i[6:2] == opcode_system) && (instr_i[1:0] == 2'b11);
    assign funct3    = instr_i[14:12];
    assign imm       = instr_i[31:20];

    always_comb begin
        csr_req_o  = '0;
        trap_evt_o = '0;
        if (is_system) begin
            case (funct3)
                funct3_csrrw: begin
                    csr_req_o.wr_en = 1'b1;
                    csr_req_o.op    = op_rw;
                    csr_req_o.addr  = imm;
                end
                funct3_csrrs: begin
                    csr_req_o.wr_en = 1'b1;
                    csr_req_o.op    = op_rs;
                    csr_req_o.addr  = imm;
                end
                funct3_csrrc: begin
                    csr_req_o.wr_en = 1'b1;
                    csr_req_o.op    = op_rc;
                    csr_req_o.addr  = imm;
                end
                funct3_priv: begin
                    // ecall and mret share funct3, told apart by imm
                    if (imm == imm_ecall) begin
                        trap_evt_o.ecall = 1'b1;
                    end else if (imm == imm_mret) begin
                        trap_evt_o.mret = 1'b1;
                    end
                end
                default: begin
                    // immediate forms and reserved codes stay idle
                    csr_req_o = '0;
                end
            endcase
        end
    end

    // csr_file and trap_redirect both rely on a single event per instruction
    trap_evt_excl: assert final (!(trap_evt_o.ecall && trap_evt_o.mret))
        else $error("ecall and mret decoded together");

endmodule

// File: rtl/csr_file.sv
`timescale 1ns/1ns
module csr_file #(
    parameter int XLEN = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_req_t  csr_req_i,
    input  csr_pkg::trap_evt_t trap_evt_i,
    input  logic [XLEN-1:0]    pc_i,
    input  logic [XLEN-1:0]    wdata_i,
    input  logic               stall_n_i,
    output logic [XLEN-1:0]    rdata_o,
    output logic [XLEN-1:0]    mtvec_o,
    output logic [XLEN-1:0]    mepc_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mcause_q;
    logic            mie_q;
    logic            mpie_q;
    logic [1:0]      mpp_q;
    logic [XLEN-1:0] mstatus_val;

    // select order: mepc, mtvec, mstatus, mcause
    logic [3:0]      sel;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic            csr_we;
    logic            ecall_acc;
    logic            mret_acc;

    assign sel[0] = csr_req_i.wr_en && (csr_req_i.addr == csr_addr_mepc);
    assign sel[1] = csr_req_i.wr_en && (csr_req_i.addr == csr_addr_mtvec);
    assign sel[2] = csr_req_i.wr_en && (csr_req_i.addr == csr_addr_mstatus);
    assign sel[3] = csr_req_i.wr_en && (csr_req_i.addr == csr_addr_mcause);

    always_comb begin
        mstatus_val                        = '0;
        mstatus_val[mstatus_mie_bit]       = mie_q;
        mstatus_val[mstatus_mpie_bit]      = mpie_q;
        mstatus_val[mstatus_mpp_lsb +: 2]  = mpp_q;
    end

    // and-or mux, unknown address falls through to zero
    assign old_val = ({XLEN{sel[0]}} & mepc_q)
                   | ({XLEN{sel[1]}} & mtvec_q)
                   | ({XLEN{sel[2]}} & mstatus_val)
                   | ({XLEN{sel[3]}} & mcause_q);

    always_comb begin
        case (csr_req_i.op)
            op_rw:   new_val = wdata_i;
            op_rs:   new_val = old_val | wdata_i;
            op_rc:   new_val = old_val & ~wdata_i;
            default: new_val = old_val;
        endcase
    end

    assign csr_we    = csr_req_i.wr_en && stall_n_i;
    assign ecall_acc = trap_evt_i.ecall && stall_n_i;
    assign mret_acc  = trap_evt_i.mret && stall_n_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q <= '0;
        end else if (ecall_acc) begin
            mepc_q <= {pc_i[XLEN-1:2], 2'b00};
        end else if (csr_we && sel[0]) begin
            mepc_q <= {new_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (csr_we && sel[1]) begin
            // direct mode only
            mtvec_q <= {new_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q  <= mstatus_reset[mstatus_mie_bit];
            mpie_q <= mstatus_reset[mstatus_mpie_bit];
            mpp_q  <= mstatus_reset[mstatus_mpp_lsb +: 2];
        end else if (ecall_acc) begin
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
            mpp_q  <= 2'b11;
        end else if (mret_acc) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (csr_we && sel[2]) begin
            mie_q  <= new_val[mstatus_mie_bit];
            mpie_q <= new_val[mstatus_mpie_bit];
            mpp_q  <= new_val[mstatus_mpp_lsb +: 2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause_q <= '0;
        end else if (ecall_acc) begin
            mcause_q <= XLEN'(cause_ecall_m);
        end else if (csr_we && sel[3]) begin
            mcause_q <= new_val;
        end
    end

    assign rdata_o = old_val;
    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

    sel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sel));

    // decoder must never flag a trap on a CSR access
    no_trap_and_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(csr_req_i.wr_en && (trap_evt_i.ecall || trap_evt_i.mret)));

    vec_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (mepc_q[1:0] == 2'b00) && (mtvec_q[1:0] == 2'b00));

endmodule

// File: rtl/csr_pkg.sv
package csr_pkg;

    // machine CSR addresses
    localparam logic [11:0] csr_addr_mstatus = 12'h300;
    localparam logic [11:0] csr_addr_mtvec   = 12'h305;
    localparam logic [11:0] csr_addr_mepc    = 12'h341;
    localparam logic [11:0] csr_addr_mcause  = 12'h342;

    // SYSTEM major opcode, instr[6:2]
    localparam logic [4:0] opcode_system = 5'b11100;

    // funct3 of the SYSTEM group
    localparam logic [2:0] funct3_priv  = 3'd0;
    localparam logic [2:0] funct3_csrrw = 3'd1;
    localparam logic [2:0] funct3_csrrs = 3'd2;
    localparam logic [2:0] funct3_csrrc = 3'd3;

    // imm field when funct3 is zero
    localparam logic [11:0] imm_ecall = 12'h000;
    localparam logic [11:0] imm_mret  = 12'h302;

    // mstatus fields kept by this core
    localparam int unsigned mstatus_mie_bit  = 3;
    localparam int unsigned mstatus_mpie_bit = 7;
    localparam int unsigned mstatus_mpp_lsb  = 11;
    localparam logic [31:0] mstatus_reset    = 32'h0000_1800;

    // environment call from M-mode
    localparam logic [31:0] cause_ecall_m = 32'd11;

    typedef enum logic [1:0] {
        op_none = 2'd0,
        op_rw   = 2'd1,
        op_rs   = 2'd2,
        op_rc   = 2'd3
    } csr_op_e;

    typedef struct packed {
        logic        wr_en;
        csr_op_e     op;
        logic [11:0] addr;
    } csr_req_t;

    typedef struct packed {
        logic ecall;
        logic mret;
    } trap_evt_t;

endpackage

// File: rtl/csr_unit_top.sv
`timescale 1ns/1ns
module csr_unit_top #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] pc_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] csr_wdata_i,
    input  logic            stall_n_i,
    output logic [XLEN-1:0] csr_rdata_o,
    output logic            redirect_valid_o,
    output logic [XLEN-1:0] redirect_pc_o
);
    import csr_pkg::*;

    csr_req_t        csr_req;
    trap_evt_t       trap_evt;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    csr_decode u_decode (
        .instr_i    (instr_i),
        .csr_req_o  (csr_req),
        .trap_evt_o (trap_evt)
    );

    csr_file #(.XLEN(XLEN)) u_csr_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_req_i  (csr_req),
        .trap_evt_i (trap_evt),
        .pc_i       (pc_i),
        .wdata_i    (csr_wdata_i),
        .stall_n_i  (stall_n_i),
        .rdata_o    (csr_rdata_o),
        .mtvec_o    (mtvec),
        .mepc_o     (mepc)
    );

    trap_redirect #(.XLEN(XLEN)) u_redirect (
        .clk              (clk),
        .rst_n            (rst_n),
        .trap_evt_i       (trap_evt),
        .stall_n_i        (stall_n_i),
        .mtvec_i          (mtvec),
        .mepc_i           (mepc),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

// File: rtl/trap_redirect.sv
`timescale 1ns/1ns
module trap_redirect #(
    parameter int XLEN = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::trap_evt_t trap_evt_i,
    input  logic               stall_n_i,
    input  logic [XLEN-1:0]    mtvec_i,
    input  logic [XLEN-1:0]    mepc_i,
    output logic               redirect_valid_o,
    output logic [XLEN-1:0]    redirect_pc_o
);
    import csr_pkg::*;

    trap_evt_t evt;
    logic      evt_acc;

    assign evt     = trap_evt_i;
    assign evt_acc = stall_n_i && (evt.ecall || evt.mret);

    // pulse lasts one cycle unless another event is accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid_o <= 1'b0;
        end else begin
            redirect_valid_o <= evt_acc;
        end
    end

    // mtvec and mepc are sampled before this edge's CSR update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_pc_o <= '0;
        end else if (evt_acc) begin
            redirect_pc_o <= evt.ecall ? mtvec_i : mepc_i;
        end
    end

    valid_needs_event: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid_o |-> $past(evt_acc));

endmodule

// File: testbench/csr_unit_checker.sv
`timescale 1ns/1ns
module csr_unit_checker #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            row_valid_i,
    input  logic [8*24-1:0] row_name_i,
    input  logic [XLEN-1:0] exp_rdata_i,
    input  logic            exp_redir_valid_i,
    input  logic [XLEN-1:0] exp_redir_pc_i,
    input  logic [XLEN-1:0] rdata_i,
    input  logic            redirect_valid_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    output int              pass_count_o,
    output int              fail_count_o
);
    // rdata is judged on the row's own edge, the redirect one edge later
    logic            pend_valid;
    logic [8*24-1:0] pend_name;
    logic [XLEN-1:0] pend_rdata_got;
    logic [XLEN-1:0] pend_rdata_exp;
    logic            pend_redir_valid;
    logic [XLEN-1:0] pend_redir_pc;

    initial begin
        pend_valid   = 1'b0;
        pass_count_o = 0;
        fail_count_o = 0;
    end

    task automatic finish_row();
        string msg;
        msg = "";
        if (pend_rdata_got !== pend_rdata_exp) begin
            msg = {msg, $sformatf(" rdata %h, expected %h;", pend_rdata_got, pend_rdata_exp)};
        end
        if (redirect_valid_i !== pend_redir_valid) begin
            msg = {msg, $sformatf(" redirect_valid %b, expected %b;",
                                  redirect_valid_i, pend_redir_valid)};
        end
        if (redirect_pc_i !== pend_redir_pc) begin
            msg = {msg, $sformatf(" redirect_pc %h, expected %h;", redirect_pc_i, pend_redir_pc)};
        end
        if (msg.len() == 0) begin
            $display("PASS   %0s", pend_name);
            pass_count_o++;
        end else begin
            $display("FAILED at %0t ns: %0s:%0s", $time, pend_name, msg);
            fail_count_o++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (pend_valid) begin
                finish_row();
            end
            pend_valid = row_valid_i;
            if (row_valid_i) begin
                pend_name        = row_name_i;
                pend_rdata_got   = rdata_i;
                pend_rdata_exp   = exp_rdata_i;
                pend_redir_valid = exp_redir_valid_i;
                pend_redir_pc    = exp_redir_pc_i;
            end
        end
    end

endmodule

// File: testbench/tb_csr_unit.sv
`timescale 1ns/1ns
module tb_csr_unit;
    import csr_pkg::*;

    localparam int          XLEN       = 32;
    localparam logic [31:0] nop_instr  = 32'h0000_0013;
    localparam logic [11:0] addr_unused = 12'h7c0;
    localparam logic [31:0] mtvec_val  = 32'h8000_0100;
    localparam logic [31:0] ecall_pc   = 32'h0000_0200;

    typedef struct packed {
        logic [31:0]     instr;
        logic [31:0]     pc;
        logic [31:0]     wdata;
        logic            stall_n;
        logic [31:0]     rdata;
        logic            redir_valid;
        logic [31:0]     redir_pc;
        logic [8*24-1:0] name;
    } row_t;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic [XLEN-1:0] wdata;
    logic            stall_n;
    logic [XLEN-1:0] rdata;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;

    // expectations handed to the checker
    logic            row_valid;
    logic [8*24-1:0] row_name;
    logic [XLEN-1:0] exp_rdata;
    logic            exp_redir_valid;
    logic [XLEN-1:0] exp_redir_pc;

    int     pass_count;
    int     fail_count;
    row_t   table_q[$];
    integer seed;
    int     cycle_cnt;
    int     cycle_limit;

    csr_unit_top #(.XLEN(XLEN)) u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .pc_i             (pc),
        .instr_i          (instr),
        .csr_wdata_i      (wdata),
        .stall_n_i        (stall_n),
        .csr_rdata_o      (rdata),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    csr_unit_checker #(.XLEN(XLEN)) u_chk (
        .clk               (clk),
        .rst_n             (rst_n),
        .row_valid_i       (row_valid),
        .row_name_i        (row_name),
        .exp_rdata_i       (exp_rdata),
        .exp_redir_valid_i (exp_redir_valid),
        .exp_redir_pc_i    (exp_redir_pc),
        .rdata_i           (rdata),
        .redirect_valid_i  (redirect_valid),
        .redirect_pc_i     (redirect_pc),
        .pass_count_o      (pass_count),
        .fail_count_o      (fail_count)
    );

    // SYSTEM instruction word with rs1 and rd fixed at x5 for CSR accesses
    function automatic logic [31:0] encode_system(input logic [2:0] funct3,
                                                  input logic [11:0] imm);
        logic [4:0] reg_idx;
        reg_idx = (funct3 == funct3_priv) ? 5'd0 : 5'd5;
        return {imm, reg_idx, funct3, reg_idx, opcode_system, 2'b11};
    endfunction

    task automatic add_row(input logic [31:0] instr_v, input logic [31:0] pc_v,
                           input logic [31:0] wdata_v, input logic stall_v,
                           input logic [31:0] rdata_v, input logic rv_v,
                           input logic [31:0] rpc_v, input logic [8*24-1:0] name_v);
        table_q.push_back({instr_v, pc_v, wdata_v, stall_v, rdata_v, rv_v, rpc_v, name_v});
    endtask

    task automatic build_table();
        logic [31:0] rs_mstatus, rc_mstatus, rs_mtvec, rw_mtvec, rs_mepc, rw_mepc;
        logic [31:0] rs_mcause, rs_unused, rw_unused, ecall_word, mret_word;
        rs_mstatus = encode_system(funct3_csrrs, csr_addr_mstatus);
        rc_mstatus = encode_system(funct3_csrrc, csr_addr_mstatus);
        rs_mtvec   = encode_system(funct3_csrrs, csr_addr_mtvec);
        rw_mtvec   = encode_system(funct3_csrrw, csr_addr_mtvec);
        rs_mepc    = encode_system(funct3_csrrs, csr_addr_mepc);
        rw_mepc    = encode_system(funct3_csrrw, csr_addr_mepc);
        rs_mcause  = encode_system(funct3_csrrs, csr_addr_mcause);
        rs_unused  = encode_system(funct3_csrrs, addr_unused);
        rw_unused  = encode_system(funct3_csrrw, addr_unused);
        ecall_word = encode_system(funct3_priv, imm_ecall);
        mret_word  = encode_system(funct3_priv, imm_mret);
        // instr, pc, wdata, stall_n, rdata, next redirect valid and pc, name
        add_row(rs_mstatus, '0, '0, 1'b1, 32'h1800, 1'b0, '0, "mstatus reset");
        add_row(rs_mtvec, '0, '0, 1'b1, '0, 1'b0, '0, "mtvec reset");
        add_row(rs_mepc, '0, '0, 1'b1, '0, 1'b0, '0, "mepc reset");
        add_row(rs_mcause, '0, '0, 1'b1, '0, 1'b0, '0, "mcause reset");
        add_row(rw_mtvec, '0, 32'h8000_0103, 1'b1, '0, 1'b0, '0, "csrrw mtvec");
        add_row(rs_mtvec, '0, '0, 1'b1, mtvec_val, 1'b0, '0, "mtvec aligned readback");
        add_row(rs_mstatus, '0, 32'h88, 1'b1, 32'h1800, 1'b0, '0, "csrrs mstatus");
        add_row(rc_mstatus, '0, 32'h80, 1'b1, 32'h1888, 1'b0, '0, "csrrc mstatus");
        add_row(rs_mstatus, '0, '0, 1'b1, 32'h1808, 1'b0, '0, "mstatus after clear");
        add_row(rw_unused, '0, 32'hdead_beef, 1'b1, '0, 1'b0, '0, "unknown csr write");
        add_row(rs_unused, '0, '0, 1'b1, '0, 1'b0, '0, "unknown csr read");
        add_row(rs_mtvec, '0, '0, 1'b1, mtvec_val, 1'b0, '0, "mtvec after unknown");
        add_row(rs_mstatus, '0, '0, 1'b1, 32'h1808, 1'b0, '0, "mstatus after unknown");
        add_row(nop_instr, '0, $random(seed), 1'b1, '0, 1'b0, '0, "nop filler");
        // stalled ecall and write must leave no trace
        add_row(ecall_word, ecall_pc, '0, 1'b0, '0, 1'b0, '0, "ecall stalled");
        add_row(rw_mtvec, '0, 32'h1234_5678, 1'b0, mtvec_val, 1'b0, '0, "csrrw mtvec stalled");
        add_row(rs_mtvec, '0, '0, 1'b1, mtvec_val, 1'b0, '0, "mtvec after stall");
        add_row(rs_mepc, '0, '0, 1'b1, '0, 1'b0, '0, "mepc after stall");
        add_row(rs_mcause, '0, '0, 1'b1, '0, 1'b0, '0, "mcause after stall");
        add_row(ecall_word, ecall_pc, '0, 1'b1, '0, 1'b1, mtvec_val, "ecall");
        add_row(rs_mepc, '0, '0, 1'b1, ecall_pc, 1'b0, mtvec_val, "mepc after ecall");
        add_row(rs_mcause, '0, '0, 1'b1, 32'd11, 1'b0, mtvec_val, "mcause after ecall");
        add_row(rs_mstatus, '0, '0, 1'b1, 32'h1880, 1'b0, mtvec_val, "mstatus after ecall");
        add_row(mret_word, 32'h300, '0, 1'b1, '0, 1'b1, ecall_pc, "mret");
        add_row(rs_mstatus, '0, '0, 1'b1, 32'h1888, 1'b0, ecall_pc, "mstatus after mret");
        add_row(rw_mtvec, '0, 32'h1234_5678, 1'b1, mtvec_val, 1'b0, ecall_pc, "csrrw mtvec retry");
        add_row(rs_mtvec, '0, '0, 1'b1, 32'h1234_5678, 1'b0, ecall_pc, "mtvec after retry");
        add_row(rw_mepc, '0, 32'h1000, 1'b1, ecall_pc, 1'b0, ecall_pc, "mepc back-to-back 1");
        add_row(rw_mepc, '0, 32'h2004, 1'b1, 32'h1000, 1'b0, ecall_pc, "mepc back-to-back 2");
        add_row(rw_mepc, '0, 32'h3008, 1'b1, 32'h2004, 1'b0, ecall_pc, "mepc back-to-back 3");
        add_row(rs_mepc, '0, '0, 1'b1, 32'h3008, 1'b0, ecall_pc, "mepc readback");
        add_row(nop_instr, '0, $random(seed), 1'b1, '0, 1'b0, ecall_pc, "nop filler");
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        row_t row;
        rst_n           = 1'b0;
        instr           = nop_instr;
        pc              = '0;
        wdata           = '0;
        stall_n         = 1'b0;
        row_valid       = 1'b0;
        row_name        = '0;
        exp_rdata       = '0;
        exp_redir_valid = 1'b0;
        exp_redir_pc    = '0;
        cycle_cnt       = 0;
        seed            = 32'h105e;
        build_table();
        cycle_limit = table_q.size() * 4 + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < table_q.size(); i++) begin
            @(negedge clk);
            row             = table_q[i];
            instr           = row.instr;
            pc              = row.pc;
            wdata           = row.wdata;
            stall_n         = row.stall_n;
            exp_rdata       = row.rdata;
            exp_redir_valid = row.redir_valid;
            exp_redir_pc    = row.redir_pc;
            row_name        = row.name;
            row_valid       = 1'b1;
        end
        @(negedge clk);
        row_valid = 1'b0;
        instr     = nop_instr;
        stall_n   = 1'b0;
        // last row's redirect is judged one edge later
        repeat (2) @(negedge clk);
        if (pass_count + fail_count != table_q.size()) begin
            $display("checker reported %0d rows but the table has %0d",
                     pass_count + fail_count, table_q.size());
        end
        $display("totals: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == table_q.size()) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_file.sv
rtl/trap_redirect.sv
rtl/csr_unit_top.sv
testbench/csr_unit_checker.sv
testbench/tb_csr_unit.sv
